//--- hw/spi_pkg.sv
`default_nettype none

package spi_pkg;

  // --------------------
  // Data types
  // --------------------

  // One SPI byte
  typedef logic [7:0] byte_t;

  // Transmit queue entry
  typedef struct packed {
    byte_t data;
    // Release chip select after this byte
    logic  last;
  } tx_item_t;

  // Control register, enable in bit 4
  typedef struct packed {
    logic       enable;
    // Half period is clk_div + 1 cycles
    logic [3:0] clk_div;
  } ctrl_t;

  // APB request, driven from outside
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // --------------------
  // Register map
  // --------------------
  localparam logic [3:0] ADDR_CTRL   = 4'h0;
  localparam logic [3:0] ADDR_STATUS = 4'h4;
  localparam logic [3:0] ADDR_TXDATA = 4'h8;
  localparam logic [3:0] ADDR_RXDATA = 4'hC;

  // Status word bits
  localparam int STATUS_TX_FULL_BIT  = 0;
  localparam int STATUS_RX_EMPTY_BIT = 1;
  localparam int STATUS_BUSY_BIT     = 2;

  // Last flag position in TXDATA writes
  localparam int TXDATA_LAST_BIT = 8;

endpackage

`default_nettype wire

//--- hw/spi_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module spi_fifo #(
  parameter int  FIFO_DEPTH = 4,
  parameter type item_t     = logic [7:0]
) (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  push_valid,
  input  item_t push_item,
  output logic  push_ready,
  output logic  pop_valid,
  output item_t pop_item,
  input  logic  pop_ready
);

  // Address bits, FIFO_DEPTH a power of two
  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  item_t           mem [FIFO_DEPTH];
  // Extra top bit tells full from empty
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;
  logic            full;
  logic            empty;
  logic            do_push;
  logic            do_pop;

  // --------------------
  // Flags
  // --------------------

  // Same slot, wrapped once
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
  assign empty = wr_ptr == rd_ptr;

  assign push_ready = !full;
  assign pop_valid  = !empty;

  assign do_push = push_valid && push_ready;
  assign do_pop  = pop_valid && pop_ready;

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[ADDR_W-1:0]] <= push_item;
    end
  end

  // Head item, shown whether valid or not
  assign pop_item = mem[rd_ptr[ADDR_W-1:0]];

  // Pointers
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/spi_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_apb_regs
  import spi_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output ctrl_t    ctrl,
  input  logic     busy,
  output logic     tx_push_valid,
  output tx_item_t tx_item,
  input  logic     tx_push_ready,
  input  logic     rx_pop_valid,
  input  byte_t    rx_byte,
  output logic     rx_pop_ready
);

  // --------------------
  // Bus phase decode
  // --------------------
  logic        setup;
  logic        access;
  logic        sel_ctrl;
  logic        sel_status;
  logic        sel_txdata;
  logic        sel_rxdata;
  logic        err;
  logic [31:0] status_word;
  logic [31:0] read_mux;
  logic [31:0] prdata_reg;
  logic        rd_ok_reg;
  ctrl_t       ctrl_reg;

  // First cycle of a transfer
  assign setup  = apb_req.psel && !apb_req.penable;
  // Second cycle, where the access takes effect
  assign access = apb_req.psel && apb_req.penable;

  assign sel_ctrl   = apb_req.paddr == ADDR_CTRL;
  assign sel_status = apb_req.paddr == ADDR_STATUS;
  assign sel_txdata = apb_req.paddr == ADDR_TXDATA;
  assign sel_rxdata = apb_req.paddr == ADDR_RXDATA;

  // --------------------
  // Read path
  // --------------------

  // Status word from FIFO flags and engine state
  always_comb begin
    status_word                      = '0;
    status_word[STATUS_TX_FULL_BIT]  = !tx_push_ready;
    status_word[STATUS_RX_EMPTY_BIT] = !rx_pop_valid;
    status_word[STATUS_BUSY_BIT]     = busy;
  end

  always_comb begin
    case (apb_req.paddr)
      ADDR_CTRL:   read_mux = {{(32 - $bits(ctrl_t)){1'b0}}, ctrl_reg};
      ADDR_STATUS: read_mux = status_word;
      ADDR_RXDATA: read_mux = {24'h0, rx_byte};
      default:     read_mux = '0;
    endcase
  end

  // Read data captured in setup, so it is ready in the access cycle
  always_ff @(posedge clk) begin
    if (setup) begin
      prdata_reg <= read_mux;
    end
  end

  // Receive FIFO state seen in setup
  // Only this block pops, so a valid head stays valid into access
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_ok_reg <= 1'b0;
    end else if (setup) begin
      rd_ok_reg <= rx_pop_valid;
    end
  end

  // --------------------
  // Control register
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      ctrl_reg <= '0;
    end else if (access && apb_req.pwrite && sel_ctrl) begin
      ctrl_reg <= ctrl_t'(apb_req.pwdata[$bits(ctrl_t)-1:0]);
    end
  end

  assign ctrl = ctrl_reg;

  // --------------------
  // Error decode
  // --------------------
  always_comb begin
    err = 1'b0;
    if (apb_req.pwrite) begin
      if (sel_txdata) begin
        // Full transmit queue
        err = !tx_push_ready;
      end else if (!sel_ctrl) begin
        // Read only or unmapped
        err = 1'b1;
      end
    end else begin
      if (sel_rxdata) begin
        // Nothing received yet
        err = !rd_ok_reg;
      end else if (!sel_ctrl && !sel_status) begin
        // Write only or unmapped
        err = 1'b1;
      end
    end
  end

  // --------------------
  // Queue strobes
  // --------------------

  // One cycle push per TXDATA write, dropped by the FIFO when full
  assign tx_push_valid = access && apb_req.pwrite && sel_txdata;
  assign tx_item       = '{data: apb_req.pwdata[7:0], last: apb_req.pwdata[TXDATA_LAST_BIT]};

  // One cycle pop per good RXDATA read
  assign rx_pop_ready = access && !apb_req.pwrite && sel_rxdata && rd_ok_reg;

  // No wait states
  assign apb_rsp = '{prdata: prdata_reg, pready: 1'b1, pslverr: access && err};

endmodule

`default_nettype wire

//--- hw/spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine
  import spi_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  ctrl_t    ctrl,
  output logic     busy,
  input  logic     tx_valid,
  input  tx_item_t tx_item,
  output logic     tx_ready,
  output logic     rx_valid,
  output byte_t    rx_byte,
  input  logic     rx_ready,
  output logic     spi_ss_n,
  output logic     spi_sck,
  output logic     spi_mosi,
  input  logic     spi_miso
);

  // --------------------
  // Registers and wires
  // --------------------
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SELECT,
    ST_HIGH,
    ST_LOW,
    ST_GAP
  } state_t;

  state_t     state_reg;
  state_t     state_new;
  logic [3:0] hp_cnt_reg;
  logic [2:0] bit_cnt_reg;
  byte_t      shift_reg;
  logic       last_reg;
  logic       ss_n_reg;
  logic       sck_reg;
  logic       rx_valid_reg;
  logic       miso_meta_reg;
  logic       miso_sync_reg;
  logic       hp_done;
  logic       start;

  // End of a half period, >= in case clk_div shrinks mid phase
  assign hp_done = hp_cnt_reg >= ctrl.clk_div;

  // Take an item only between bytes, with room for its reply
  assign tx_ready = ((state_reg == ST_IDLE) || (state_reg == ST_GAP)) &&
                    ctrl.enable && rx_ready && !rx_valid_reg;
  assign start    = tx_valid && tx_ready;

  assign busy     = state_reg != ST_IDLE;
  assign spi_ss_n = ss_n_reg;
  assign spi_sck  = sck_reg;
  // MSB first
  assign spi_mosi = shift_reg[7];
  assign rx_valid = rx_valid_reg;
  assign rx_byte  = shift_reg;

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_new = state_reg;
    case (state_reg)
      ST_IDLE: begin
        if (start) begin
          state_new = ST_SELECT;
        end
      end
      // One cycle of select before the first rise
      ST_SELECT: state_new = ST_HIGH;
      ST_HIGH: begin
        if (hp_done) begin
          state_new = ST_LOW;
        end
      end
      ST_LOW: begin
        if (hp_done) begin
          if (bit_cnt_reg != 3'd7) begin
            state_new = ST_HIGH;
          end else if (last_reg) begin
            state_new = ST_IDLE;
          end else begin
            // Burst continues, select held
            state_new = ST_GAP;
          end
        end
      end
      ST_GAP: begin
        if (start) begin
          state_new = ST_HIGH;
        end
      end
      default: state_new = ST_IDLE;
    endcase
  end

  // MISO synchronizer, no reset needed
  always_ff @(posedge clk) begin
    miso_meta_reg <= spi_miso;
    miso_sync_reg <= miso_meta_reg;
  end

  // --------------------
  // Datapath payload
  // --------------------
  always_ff @(posedge clk) begin
    if (start) begin
      shift_reg <= tx_item.data;
      last_reg  <= tx_item.last;
    end else if (state_reg == ST_HIGH && hp_done) begin
      // Sample on the falling edge
      shift_reg <= {shift_reg[6:0], miso_sync_reg};
    end
  end

  // --------------------
  // Control registers
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state_reg    <= ST_IDLE;
      hp_cnt_reg   <= '0;
      bit_cnt_reg  <= '0;
      ss_n_reg     <= 1'b1;
      sck_reg      <= 1'b0;
      rx_valid_reg <= 1'b0;
    end else begin
      state_reg <= state_new;

      // Half period counter runs only while clocking
      if ((state_reg == ST_HIGH || state_reg == ST_LOW) && !hp_done) begin
        hp_cnt_reg <= hp_cnt_reg + 1'b1;
      end else begin
        hp_cnt_reg <= '0;
      end

      if (rx_valid_reg && rx_ready) begin
        rx_valid_reg <= 1'b0;
      end

      case (state_reg)
        ST_IDLE: begin
          if (start) begin
            ss_n_reg    <= 1'b0;
            bit_cnt_reg <= '0;
          end
        end
        ST_SELECT: sck_reg <= 1'b1;
        ST_HIGH: begin
          if (hp_done) begin
            sck_reg <= 1'b0;
            // Byte complete after the eighth fall
            if (bit_cnt_reg == 3'd7) begin
              rx_valid_reg <= 1'b1;
            end
          end
        end
        ST_LOW: begin
          if (hp_done) begin
            if (bit_cnt_reg != 3'd7) begin
              sck_reg     <= 1'b1;
              bit_cnt_reg <= bit_cnt_reg + 1'b1;
            end else if (last_reg) begin
              ss_n_reg <= 1'b1;
            end
          end
        end
        ST_GAP: begin
          if (start) begin
            sck_reg     <= 1'b1;
            bit_cnt_reg <= '0;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/spi_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_top
  import spi_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     reset_n,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp,
  output logic     spi_ss_n,
  output logic     spi_sck,
  output logic     spi_mosi,
  input  logic     spi_miso
);

  // --------------------
  // Interconnect
  // --------------------
  ctrl_t    ctrl;
  logic     busy;

  // Register block to transmit FIFO
  logic     tx_push_valid;
  logic     tx_push_ready;
  tx_item_t tx_push_item;

  // Transmit FIFO to engine
  logic     tx_pop_valid;
  logic     tx_pop_ready;
  tx_item_t tx_pop_item;

  // Engine to receive FIFO
  logic     rx_push_valid;
  logic     rx_push_ready;
  byte_t    rx_push_item;

  // Receive FIFO to register block
  logic     rx_pop_valid;
  logic     rx_pop_ready;
  byte_t    rx_pop_item;

  spi_apb_regs i_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .ctrl          (ctrl),
    .busy          (busy),
    .tx_push_valid (tx_push_valid),
    .tx_item       (tx_push_item),
    .tx_push_ready (tx_push_ready),
    .rx_pop_valid  (rx_pop_valid),
    .rx_byte       (rx_pop_item),
    .rx_pop_ready  (rx_pop_ready)
  );

  spi_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .item_t     (tx_item_t)
  ) i_tx_fifo (
    .clk        (clk),
    .reset_n    (reset_n),
    .push_valid (tx_push_valid),
    .push_item  (tx_push_item),
    .push_ready (tx_push_ready),
    .pop_valid  (tx_pop_valid),
    .pop_item   (tx_pop_item),
    .pop_ready  (tx_pop_ready)
  );

  spi_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .item_t     (byte_t)
  ) i_rx_fifo (
    .clk        (clk),
    .reset_n    (reset_n),
    .push_valid (rx_push_valid),
    .push_item  (rx_push_item),
    .push_ready (rx_push_ready),
    .pop_valid  (rx_pop_valid),
    .pop_item   (rx_pop_item),
    .pop_ready  (rx_pop_ready)
  );

  spi_shift_engine i_engine (
    .clk      (clk),
    .reset_n  (reset_n),
    .ctrl     (ctrl),
    .busy     (busy),
    .tx_valid (tx_pop_valid),
    .tx_item  (tx_pop_item),
    .tx_ready (tx_pop_ready),
    .rx_valid (rx_push_valid),
    .rx_byte  (rx_push_item),
    .rx_ready (rx_push_ready),
    .spi_ss_n (spi_ss_n),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso)
  );

endmodule

`default_nettype wire

//--- sim/spi_top_sva.sv
`timescale 1ns/1ps
`default_nettype none

module spi_top_sva
  import spi_pkg::*;
(
  input logic     clk,
  input logic     reset_n,
  input apb_req_t apb_req,
  input apb_rsp_t apb_rsp,
  input logic     spi_ss_n,
  input logic     spi_sck
);

  // --------------------
  // SPI pins
  // --------------------

  // sck only moves inside a frame
  sck_quiet_when_deselected: assert property (
    @(posedge clk) disable iff (!reset_n)
    spi_ss_n |-> $stable(spi_sck)
  ) else $error("spi_sck toggled while spi_ss_n was high");

  // --------------------
  // APB
  // --------------------

  // Error response only in the access cycle
  slverr_only_in_access: assert property (
    @(posedge clk) disable iff (!reset_n)
    apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable)
  ) else $error("pslverr outside an APB access");

  // Setup is followed by an access with the same request
  request_stable_into_access: assert property (
    @(posedge clk) disable iff (!reset_n)
    (apb_req.psel && !apb_req.penable) |=>
      (apb_req.psel && apb_req.penable && $stable(apb_req.paddr) &&
       $stable(apb_req.pwrite) && $stable(apb_req.pwdata))
  ) else $error("APB request changed between setup and access");

endmodule

bind spi_top spi_top_sva i_sva (
  .clk      (clk),
  .reset_n  (reset_n),
  .apb_req  (apb_req),
  .apb_rsp  (apb_rsp),
  .spi_ss_n (spi_ss_n),
  .spi_sck  (spi_sck)
);

`default_nettype wire

//--- sim/spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spi_tb
  import spi_pkg::*;
();

  localparam int          FIFO_DEPTH  = 4;
  localparam int          CLK_HALF    = 10;
  localparam int          POLL_LIMIT  = 5000;
  localparam int          STALL_WAIT  = 300;
  localparam int          RANDOM_RUNS = 3;
  localparam logic [31:0] LFSR_SEED   = 32'h232b695e;
  localparam string       GOLDEN_FILE = "sim/spi_golden.txt";

  logic     clk;
  logic     reset_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     spi_ss_n;
  logic     spi_sck;
  logic     spi_mosi;
  logic     spi_miso = 1'b0;

  // Golden transfers, one entry per line
  byte_t       gold_tx[$];
  byte_t       gold_reply[$];
  logic        gold_last[$];
  logic [31:0] lfsr_state = LFSR_SEED;

  // SPI slave model state
  byte_t slave_replies[$];
  byte_t captured[$];
  byte_t rx_shift = '0;
  int    frames = 0;
  int    sck_edges = 0;
  int    reply_idx = 0;
  int    rise_cnt = 0;
  int    fall_cnt = 0;
  logic  sck_prev = 1'b0;
  logic  ss_prev = 1'b1;

  spi_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_dut (
    .clk      (clk),
    .reset_n  (reset_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .spi_ss_n (spi_ss_n),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_HALF) clk = ~clk;
  end

  // --------------------
  // Failure reporting
  // --------------------
  task automatic report_mismatch(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    $display("RESULT: FAIL");
    $fatal(1, "Stopping after a data mismatch");
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Stopping after a testbench failure");
  endtask

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: got 0x%02h, expected 0x%02h", what, got, exp));
    end
  endtask

  task automatic check_status(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: got 0x%08h, expected 0x%08h", what, got, exp));
    end
  endtask

  task automatic check_slverr(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: pslverr %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_pin(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s: level %b, expected %b", what, got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      report_mismatch($sformatf("%s: counted %0d, expected %0d", what, got, exp));
    end
  endtask

  // --------------------
  // Stimulus helpers
  // --------------------

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output int value);
    value = 0;
    repeat (n) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
  endtask

  function automatic logic [31:0] status_value(input logic tx_full, input logic rx_empty,
                                               input logic busy);
    logic [31:0] s;
    s = '0;
    s[STATUS_TX_FULL_BIT]  = tx_full;
    s[STATUS_RX_EMPTY_BIT] = rx_empty;
    s[STATUS_BUSY_BIT]     = busy;
    return s;
  endfunction

  function automatic logic [31:0] ctrl_word(input logic enable, input logic [3:0] clk_div);
    ctrl_t c;
    c.enable  = enable;
    c.clk_div = clk_div;
    return {27'h0, c};
  endfunction

  function automatic logic [31:0] txdata_word(input byte_t data, input logic last);
    return {23'h0, last, data};
  endfunction

  // Single burst ends only on the final item
  function automatic logic item_last(input int i, input int first, input int count);
    return i == first + count - 1;
  endfunction

  function automatic int count_lasts(input int first, input int count);
    int n;
    n = 0;
    for (int i = first; i < first + count; i++) begin
      n += int'(gold_last[i]);
    end
    return n;
  endfunction

  // Comment lines start with #
  task automatic load_golden();
    int          fd;
    int          n;
    string       line;
    byte_t       tx;
    byte_t       reply;
    logic [7:0]  last_field;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the golden transfer file");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h", tx, last_field, reply);
        if (n == 3) begin
          gold_tx.push_back(tx);
          gold_last.push_back(last_field[0]);
          gold_reply.push_back(reply);
        end
      end
    end
    $fclose(fd);
    if (gold_tx.size() < 2 * FIFO_DEPTH) begin
      abort_run("The golden file holds too few transfers");
    end
    if (!gold_last[gold_tx.size() - 1]) begin
      abort_run("The last golden transfer does not end a frame");
    end
  endtask

  // --------------------
  // APB driver
  // --------------------
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic slverr);
    int waits;
    waits = 0;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      waits++;
      if (waits > POLL_LIMIT) begin
        abort_run("Timed out waiting for pready on an APB write");
      end
      @(negedge clk);
    end
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic slverr);
    int waits;
    waits = 0;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready) begin
      waits++;
      if (waits > POLL_LIMIT) begin
        abort_run("Timed out waiting for pready on an APB read");
      end
      @(negedge clk);
    end
    data   = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic read_status(output logic [31:0] st);
    logic err;
    apb_read(ADDR_STATUS, st, err);
    check_slverr(err, 1'b0, "STATUS read");
  endtask

  task automatic set_ctrl(input logic enable, input logic [3:0] clk_div);
    logic err;
    apb_write(ADDR_CTRL, ctrl_word(enable, clk_div), err);
    check_slverr(err, 1'b0, "CTRL write");
  endtask

  task automatic wait_idle();
    int          polls;
    logic [31:0] st;
    polls = 0;
    read_status(st);
    while (st[STATUS_BUSY_BIT]) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        abort_run("Timed out waiting for the engine to go idle");
      end
      read_status(st);
    end
  endtask

  // --------------------
  // Transfer sequences
  // --------------------
  task automatic queue_replies(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      slave_replies.push_back(gold_reply[i]);
    end
  endtask

  // Writes one frame of items as the transmit queue has room, reads nothing
  task automatic write_items(input int first, input int count);
    int          polls;
    logic [31:0] st;
    logic        err;
    for (int i = first; i < first + count; i++) begin
      polls = 0;
      read_status(st);
      while (st[STATUS_TX_FULL_BIT]) begin
        polls++;
        if (polls > POLL_LIMIT) begin
          abort_run("Timed out waiting for room in the transmit queue");
        end
        read_status(st);
      end
      apb_write(ADDR_TXDATA, txdata_word(gold_tx[i], item_last(i, first, count)), err);
      check_slverr(err, 1'b0, "TXDATA write");
    end
  endtask

  task automatic read_replies(input int first, input int count);
    int          polls;
    logic [31:0] st;
    logic [31:0] rd;
    logic        err;
    for (int i = first; i < first + count; i++) begin
      polls = 0;
      read_status(st);
      while (st[STATUS_RX_EMPTY_BIT]) begin
        polls++;
        if (polls > POLL_LIMIT) begin
          abort_run("Timed out waiting for a received byte");
        end
        read_status(st);
      end
      apb_read(ADDR_RXDATA, rd, err);
      check_slverr(err, 1'b0, "RXDATA read");
      check_byte(rd[7:0], gold_reply[i], "RXDATA byte");
    end
  endtask

  // Writes and reads interleaved, so the engine never stalls
  task automatic exchange(input int first, input int count);
    int          sent;
    int          got;
    int          polls;
    logic [31:0] st;
    logic [31:0] rd;
    logic        err;
    sent  = 0;
    got   = 0;
    polls = 0;
    while (got < count) begin
      read_status(st);
      if (sent < count && !st[STATUS_TX_FULL_BIT]) begin
        apb_write(ADDR_TXDATA, txdata_word(gold_tx[first + sent], gold_last[first + sent]),
                  err);
        check_slverr(err, 1'b0, "TXDATA write");
        sent++;
      end
      if (!st[STATUS_RX_EMPTY_BIT]) begin
        apb_read(ADDR_RXDATA, rd, err);
        check_slverr(err, 1'b0, "RXDATA read");
        check_byte(rd[7:0], gold_reply[first + got], "RXDATA byte");
        got++;
      end
      polls++;
      if (polls > count * POLL_LIMIT) begin
        abort_run("Timed out waiting for the golden transfers to finish");
      end
    end
  endtask

  task automatic check_capture(input int cap_base, input int first, input int count);
    check_count(captured.size() - cap_base, count, "bytes seen by the SPI slave");
    for (int i = 0; i < count; i++) begin
      check_byte(captured[cap_base + i], gold_tx[first + i], "MOSI byte at the slave");
    end
  endtask

  task automatic run_golden(input logic [3:0] clk_div);
    int cap_base;
    int frame_base;
    cap_base   = captured.size();
    frame_base = frames;
    set_ctrl(1'b1, clk_div);
    queue_replies(0, gold_tx.size());
    exchange(0, gold_tx.size());
    wait_idle();
    check_capture(cap_base, 0, gold_tx.size());
    check_count(frames - frame_base, count_lasts(0, gold_tx.size()), "chip select frames");
    check_pin(spi_ss_n, 1'b1, "spi_ss_n after the golden burst");
  endtask

  // --------------------
  // SPI slave model
  // --------------------
  function automatic logic reply_bit(input int idx, input int pos);
    byte_t r;
    r = (idx < slave_replies.size()) ? slave_replies[idx] : 8'h00;
    return r[pos];
  endfunction

  // Edges seen one clk late, MISO moves right after each fall
  always @(posedge clk) begin
    if (ss_prev === 1'b1 && spi_ss_n === 1'b0) begin
      fall_cnt = 0;
      spi_miso <= reply_bit(reply_idx, 7);
    end
    if (ss_prev === 1'b0 && spi_ss_n === 1'b1) begin
      frames++;
    end
    if (sck_prev === 1'b0 && spi_sck === 1'b1) begin
      sck_edges++;
      rx_shift = {rx_shift[6:0], spi_mosi};
      rise_cnt++;
      if (rise_cnt == 8) begin
        captured.push_back(rx_shift);
        rise_cnt = 0;
      end
    end
    if (sck_prev === 1'b1 && spi_sck === 1'b0) begin
      sck_edges++;
      // Eighth fall moves on to the next reply
      if (fall_cnt == 7) begin
        fall_cnt = 0;
        reply_idx++;
      end else begin
        fall_cnt++;
      end
      spi_miso <= reply_bit(reply_idx, 7 - fall_cnt);
    end
    sck_prev = spi_sck;
    ss_prev  = spi_ss_n;
  end

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    logic [31:0] st;
    logic [31:0] rd;
    logic        err;
    int          cap_base;
    int          frame_base;
    int          edge_base;
    int          waits;
    int          div;

    reset_n = 1'b0;
    apb_req = '0;
    load_golden();
    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);

    // Reset state
    read_status(st);
    check_status(st, status_value(1'b0, 1'b1, 1'b0), "STATUS after reset");
    check_pin(spi_ss_n, 1'b1, "spi_ss_n after reset");
    apb_read(ADDR_RXDATA, rd, err);
    check_slverr(err, 1'b1, "RXDATA read when empty");

    // Golden transfers and frames at clk_div 2
    run_golden(4'd2);

    // Disabled engine, full transmit queue
    set_ctrl(1'b0, 4'd2);
    edge_base  = sck_edges;
    cap_base   = captured.size();
    frame_base = frames;
    queue_replies(0, FIFO_DEPTH);
    write_items(0, FIFO_DEPTH);
    read_status(st);
    check_status(st, status_value(1'b1, 1'b1, 1'b0), "STATUS with full transmit queue");
    apb_write(ADDR_TXDATA, txdata_word(8'hEE, 1'b1), err);
    check_slverr(err, 1'b1, "TXDATA write when full");
    check_count(sck_edges - edge_base, 0, "sck edges while disabled");
    set_ctrl(1'b1, 4'd2);
    read_replies(0, FIFO_DEPTH);
    wait_idle();
    check_capture(cap_base, 0, FIFO_DEPTH);
    check_count(frames - frame_base, 1, "frames after enabling");

    // Back-pressure from a full receive queue
    cap_base   = captured.size();
    frame_base = frames;
    queue_replies(0, 2 * FIFO_DEPTH);
    write_items(0, 2 * FIFO_DEPTH);
    waits = 0;
    @(negedge clk);
    while (captured.size() - cap_base < FIFO_DEPTH) begin
      waits++;
      if (waits > POLL_LIMIT) begin
        abort_run("Timed out waiting for the receive queue to fill");
      end
      @(negedge clk);
    end
    // Window in which a stalled engine must not move
    repeat (STALL_WAIT) @(negedge clk);
    check_count(captured.size() - cap_base, FIFO_DEPTH, "bytes sent into a full queue");
    read_status(st);
    check_status(st, status_value(1'b1, 1'b0, 1'b1), "STATUS while stalled");
    check_pin(spi_ss_n, 1'b0, "spi_ss_n during the stall");
    read_replies(0, 2 * FIFO_DEPTH);
    wait_idle();
    check_capture(cap_base, 0, 2 * FIFO_DEPTH);
    check_count(frames - frame_base, 1, "frames across the stall");

    // Random clock dividers from 2 to 15
    for (int run = 0; run < RANDOM_RUNS; run++) begin
      random_bits(4, div);
      run_golden(4'(2 + div % 14));
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/spi_pkg.sv
hw/spi_fifo.sv
hw/spi_apb_regs.sv
hw/spi_shift_engine.sv
hw/spi_top.sv
sim/spi_top_sva.sv
sim/spi_tb.sv

//--- Makefile
# Project files and tools, all overridable from the command line
TOP       ?= spi_tb
SRC       ?= verilog.f
FLAGS     ?= --timing --assert
BUILD     ?= obj_dir
VERILATOR ?= verilator

.PHONY: all lint sim clean

all: sim

# Static checks on RTL and testbench
lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(SRC)

# Build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(SRC)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

//--- sim/spi_golden.txt
# tx_data last reply_data, all hex, one SPI transfer per line
# last=1 releases chip select after the byte
3C 0 A5
81 0 5A
00 0 FF
FF 1 00
96 0 C3
69 0 3C
12 1 ED
7E 1 81
A5 0 0F
5A 0 F0
C3 0 69
0F 1 96
F0 0 24
24 0 DB
DB 0 7E
E7 1 18
